// ==== logic/pmu_settings.svh ====
`ifndef PMU_SETTINGS_SVH
`define PMU_SETTINGS_SVH

// Flops in each input synchronizer chain
// Two is the minimum for metastability settling
`define PMU_SYNC_STAGES 2

// Reset pattern of the synchronized inputs, bit order as in pmu_pkg::sync_vec_t
// Bit 4 power-down acknowledge, resets high
// Bit 3 sleepdeep, bit 2 wakeup, bit 1 WIC acknowledge, all reset low
// Bit 0 sleep-hold acknowledge (active low), resets high
`define PMU_SYNC_RESET_LEVELS 5'b10001

`endif

// ==== logic/pmu_pkg.sv ====
package pmu_pkg;

  // --------------------------------------------------
  // Power state of the switchable SYS domain
  // --------------------------------------------------
  typedef enum logic [1:0]
  {
    powered_up    = 2'b00,
    powering_down = 2'b01,
    powered_down  = 2'b10,
    powering_up   = 2'b11
  } power_state_t;

  // --------------------------------------------------
  // Synchronized asynchronous inputs
  // --------------------------------------------------
  localparam int SYNC_WIDTH = 5;

  typedef logic [SYNC_WIDTH-1:0] sync_vec_t;

  // Bit positions within sync_vec_t
  localparam int SYNC_HOLDACK_N = 0;
  localparam int SYNC_WICENACK  = 1;
  localparam int SYNC_WAKEUP    = 2;
  localparam int SYNC_SLEEPDEEP = 3;
  localparam int SYNC_PDACK     = 4;

endpackage

// ==== logic/pmu_input_sync.sv ====
`timescale 1ns/1ps

`include "pmu_settings.svh"

module pmu_input_sync
(
  input  logic                FCLK,
  input  logic                PORESETn,
  input  pmu_pkg::sync_vec_t  async_in,
  output pmu_pkg::sync_vec_t  sync_in
);

  // --------------------------------------------------
  // Synchronizer chains
  // --------------------------------------------------

  // One vector per stage, so each bit has its own chain
  // Stage 0 samples the raw input, the last stage feeds the logic
  pmu_pkg::sync_vec_t sync_q [`PMU_SYNC_STAGES];

  always_ff @(posedge FCLK or negedge PORESETn)
  begin
    if (!PORESETn)
    begin
      // Per-bit reset level keeps active-low acks deasserted
      // and the power-down ack reading as a switched-off domain
      for (int i = 0; i < `PMU_SYNC_STAGES; i++)
      begin
        sync_q[i] <= `PMU_SYNC_RESET_LEVELS;
      end
    end
    else
    begin
      // First stage, may go metastable
      sync_q[0] <= async_in;
      // Remaining stages settle the level
      for (int i = 1; i < `PMU_SYNC_STAGES; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Level appears PMU_SYNC_STAGES cycles after the input
  assign sync_in = sync_q[`PMU_SYNC_STAGES-1];

endmodule

// ==== logic/pmu_sleep_hold.sv ====
`timescale 1ns/1ps

module pmu_sleep_hold
(
  input  logic                   FCLK,
  input  logic                   PORESETn,
  input  logic                   pmu_enable,
  input  logic                   hresetreq,
  input  pmu_pkg::sync_vec_t     sync_in,
  input  pmu_pkg::power_state_t  sys_state,
  input  logic                   sys_state_change,
  output logic                   wicenreq,
  output logic                   sleepholdreq_n,
  output logic                   wake_req,
  output logic                   pdw_ok
);

  logic sys_up;
  logic set_wicreq;
  logic clr_wicreq;
  logic in_wic_ds;
  logic sleephold_q;
  logic set_hold;
  logic clr_hold;

  // Domain settled in the powered-up state
  assign sys_up = (sys_state == pmu_pkg::powered_up);

  // --------------------------------------------------
  // WIC enable request
  // --------------------------------------------------

  // Set straight from the enable
  // Cleared only once the domain is up and stable
  assign set_wicreq = pmu_enable;
  assign clr_wicreq = ~pmu_enable & sys_up & ~sys_state_change;

  always_ff @(posedge FCLK or negedge PORESETn)
  begin
    if (!PORESETn)
      wicenreq <= 1'b0;
    else if (set_wicreq | clr_wicreq)
      wicenreq <= set_wicreq;
  end

  // WIC-based deep sleep needs request, ack and sleepdeep together
  assign in_wic_ds = wicenreq & sync_in[pmu_pkg::SYNC_WICENACK] &
                     sync_in[pmu_pkg::SYNC_SLEEPDEEP];

  // A disabled PMU counts as a wake source too
  assign wake_req = sync_in[pmu_pkg::SYNC_WAKEUP] | hresetreq | ~pmu_enable;

  // --------------------------------------------------
  // Sleep extension
  // --------------------------------------------------

  // Raise the hold on deep sleep with no wake pending
  assign set_hold = ~sleephold_q & in_wic_ds & ~wake_req;

  // Drop it when sleep has ended and either
  // the domain is back up or the core never acked the hold
  assign clr_hold = sleephold_q & ~in_wic_ds &
                    (sys_up | sync_in[pmu_pkg::SYNC_HOLDACK_N]);

  always_ff @(posedge FCLK or negedge PORESETn)
  begin
    if (!PORESETn)
      sleephold_q <= 1'b0;
    else if (set_hold | clr_hold)
      sleephold_q <= set_hold;
  end

  assign sleepholdreq_n = ~sleephold_q;

  // Core is committed to sleep so power-down is safe
  assign pdw_ok = ~wake_req & in_wic_ds & sleephold_q &
                  ~sync_in[pmu_pkg::SYNC_HOLDACK_N];

endmodule

// ==== logic/pmu_sys_domain.sv ====
`timescale 1ns/1ps

module pmu_sys_domain
(
  input  logic                   FCLK,
  input  logic                   PORESETn,
  input  logic                   wake_req,
  input  logic                   pdw_ok,
  input  logic                   hresetreq,
  input  logic                   gatehclk,
  input  logic                   pwrdownack_s,
  output pmu_pkg::power_state_t  sys_state,
  output logic                   sys_state_change,
  output logic                   sysisolate_n,
  output logic                   sysretain_n,
  output logic                   syspwrdown,
  output logic                   pmu_hresetreq,
  output logic                   sclk_en,
  output logic                   hclk_en
);

  pmu_pkg::power_state_t state_nxt;

  logic going_down;
  logic going_up;
  logic iso_en;
  logic iso_d;
  logic rtn_en;
  logic rtn_d;
  logic pdn_en;
  logic pdn_d;
  logic pdw_done;
  logic pup_done;

  assign going_down = (sys_state == pmu_pkg::powering_down);
  assign going_up   = (sys_state == pmu_pkg::powering_up);

  // --------------------------------------------------
  // Domain control flops
  // --------------------------------------------------

  // Each control only loads on its own enable
  // so the pins change cleanly one step at a time

  // Isolation drops first on the way down and rises last on the way up
  assign iso_en = going_down | (going_up & sysretain_n);
  assign iso_d  = going_up;

  // Retention drops after isolation going down
  // and rises once the switch releases its ack going up
  assign rtn_en = (going_down & ~sysisolate_n) |
                  (going_up & ~syspwrdown & ~pwrdownack_s);
  assign rtn_d  = going_up;

  // Power-down rises after retention going down
  // and falls at once going up
  assign pdn_en = (going_down & ~sysretain_n) | going_up;
  assign pdn_d  = going_down;

  always_ff @(posedge FCLK or negedge PORESETn)
  begin
    if (!PORESETn)
    begin
      sysisolate_n <= 1'b0;
      sysretain_n  <= 1'b0;
      syspwrdown   <= 1'b0;
    end
    else
    begin
      if (iso_en)
        sysisolate_n <= iso_d;
      if (rtn_en)
        sysretain_n <= rtn_d;
      if (pdn_en)
        syspwrdown <= pdn_d;
    end
  end

  // Switch has confirmed power is off
  assign pdw_done = syspwrdown & pwrdownack_s;
  // Isolation about to release as the last step of power-up
  assign pup_done = iso_en & iso_d;

  // --------------------------------------------------
  // Domain state machine
  // --------------------------------------------------

  always_comb
  begin
    sys_state_change = 1'b0;
    state_nxt        = sys_state;
    case (sys_state)
      pmu_pkg::powered_up:
      begin
        sys_state_change = pdw_ok;
        state_nxt        = pmu_pkg::powering_down;
      end
      pmu_pkg::powering_down:
      begin
        sys_state_change = pdw_done;
        state_nxt        = pmu_pkg::powered_down;
      end
      pmu_pkg::powered_down:
      begin
        sys_state_change = wake_req;
        state_nxt        = pmu_pkg::powering_up;
      end
      pmu_pkg::powering_up:
      begin
        sys_state_change = pup_done;
        state_nxt        = pmu_pkg::powered_up;
      end
      default:
      begin
        sys_state_change = 1'b0;
        state_nxt        = sys_state;
      end
    endcase
  end

  // Out of reset the domain comes up from scratch
  always_ff @(posedge FCLK or negedge PORESETn)
  begin
    if (!PORESETn)
      sys_state <= pmu_pkg::powering_up;
    else if (sys_state_change)
      sys_state <= state_nxt;
  end

  // --------------------------------------------------
  // Reset extension and clock enables
  // --------------------------------------------------

  // System reset held while the domain is not fully up
  assign pmu_hresetreq = hresetreq & (sys_state != pmu_pkg::powered_up);

  assign sclk_en = (sys_state == pmu_pkg::powered_up);
  // Bus clock may also be stopped by the core
  assign hclk_en = sclk_en & ~gatehclk;

  // Controls and switch ack agree with a settled state
  sys_pdw_ok: assert property (
    @(posedge FCLK) disable iff (!PORESETn)
    (sys_state == pmu_pkg::powered_down) |->
      (!sysisolate_n && !sysretain_n && syspwrdown && pwrdownack_s)
  );

  sys_pup_ok: assert property (
    @(posedge FCLK) disable iff (!PORESETn)
    (sys_state == pmu_pkg::powered_up) |->
      (sysisolate_n && sysretain_n && !syspwrdown && !pwrdownack_s)
  );

  // Switch only acks a pending power-down request
  pdack_needs_req: assert property (
    @(posedge FCLK) disable iff (!PORESETn)
    $rose(pwrdownack_s) |-> syspwrdown
  );

endmodule

// ==== logic/pmu_top.sv ====
`timescale 1ns/1ps

module pmu_top
(
  input  logic FCLK,
  input  logic PORESETn,
  // Core and system side
  input  logic pmu_enable,
  input  logic hresetreq,
  input  logic wicenack,
  input  logic wakeup,
  input  logic sleepdeep,
  input  logic sleepholdack_n,
  input  logic gatehclk,
  // Power switch
  input  logic syspwrdownack,
  output logic wicenreq,
  output logic sleepholdreq_n,
  output logic sysisolate_n,
  output logic sysretain_n,
  output logic syspwrdown,
  output logic pmu_hresetreq,
  // Enables for the external clock gates
  output logic sclk_en,
  output logic hclk_en
);

  pmu_pkg::sync_vec_t    async_in;
  pmu_pkg::sync_vec_t    sync_in;
  pmu_pkg::power_state_t sys_state;

  logic sys_state_change;
  logic wake_req;
  logic pdw_ok;

  // --------------------------------------------------
  // Asynchronous inputs into the sync vector
  // --------------------------------------------------
  assign async_in[pmu_pkg::SYNC_HOLDACK_N] = sleepholdack_n;
  assign async_in[pmu_pkg::SYNC_WICENACK]  = wicenack;
  assign async_in[pmu_pkg::SYNC_WAKEUP]    = wakeup;
  assign async_in[pmu_pkg::SYNC_SLEEPDEEP] = sleepdeep;
  assign async_in[pmu_pkg::SYNC_PDACK]     = syspwrdownack;

  pmu_input_sync u_input_sync
  (
    .FCLK     (FCLK),
    .PORESETn (PORESETn),
    .async_in (async_in),
    .sync_in  (sync_in)
  );

  // Sleep extension and wake decisions
  pmu_sleep_hold u_sleep_hold
  (
    .FCLK             (FCLK),
    .PORESETn         (PORESETn),
    .pmu_enable       (pmu_enable),
    .hresetreq        (hresetreq),
    .sync_in          (sync_in),
    .sys_state        (sys_state),
    .sys_state_change (sys_state_change),
    .wicenreq         (wicenreq),
    .sleepholdreq_n   (sleepholdreq_n),
    .wake_req         (wake_req),
    .pdw_ok           (pdw_ok)
  );

  // SYS domain sequencer
  pmu_sys_domain u_sys_domain
  (
    .FCLK             (FCLK),
    .PORESETn         (PORESETn),
    .wake_req         (wake_req),
    .pdw_ok           (pdw_ok),
    .hresetreq        (hresetreq),
    .gatehclk         (gatehclk),
    .pwrdownack_s     (sync_in[pmu_pkg::SYNC_PDACK]),
    .sys_state        (sys_state),
    .sys_state_change (sys_state_change),
    .sysisolate_n     (sysisolate_n),
    .sysretain_n      (sysretain_n),
    .syspwrdown       (syspwrdown),
    .pmu_hresetreq    (pmu_hresetreq),
    .sclk_en          (sclk_en),
    .hclk_en          (hclk_en)
  );

endmodule

// ==== testbench/pmu_tb.sv ====
`timescale 1ns/1ps

`include "pmu_settings.svh"

module pmu_tb;

  localparam int ROWS    = 10;
  localparam int SETTLE  = `PMU_SYNC_STAGES + 4;
  localparam int TIMEOUT = 200;

  // Stimulus columns, then expected steady outputs
  typedef struct packed
  {
    logic en, sd, wk, hr, gh, rst_chk;
    logic iso, ret, pd, sclk, hclk, wic, hrq, hold_n;
  } row_t;

  logic FCLK;
  logic PORESETn;
  logic pmu_enable, hresetreq, wicenack, wakeup, sleepdeep;
  logic sleepholdack_n, gatehclk, syspwrdownack;
  logic wicenreq, sleepholdreq_n, sysisolate_n, sysretain_n;
  logic syspwrdown, pmu_hresetreq, sclk_en, hclk_en;

  logic [1:0]  pd_pipe;
  logic [2:0]  ctl_now;
  logic [2:0]  ctl_prev;
  logic [2:0]  ctl_diff;
  logic [15:0] lfsr;
  row_t        table_q [ROWS];
  int          error_count;
  int          pass_count;
  int          fail_count;

  pmu_top DUT
  (
    .FCLK (FCLK), .PORESETn (PORESETn), .pmu_enable (pmu_enable),
    .hresetreq (hresetreq), .wicenack (wicenack), .wakeup (wakeup),
    .sleepdeep (sleepdeep), .sleepholdack_n (sleepholdack_n), .gatehclk (gatehclk),
    .syspwrdownack (syspwrdownack), .wicenreq (wicenreq), .sleepholdreq_n (sleepholdreq_n),
    .sysisolate_n (sysisolate_n), .sysretain_n (sysretain_n), .syspwrdown (syspwrdown),
    .pmu_hresetreq (pmu_hresetreq), .sclk_en (sclk_en), .hclk_en (hclk_en)
  );

  initial
  begin
    FCLK = 1'b0;
    forever
      #4 FCLK = ~FCLK;
  end

  // --------------------------------------------------
  // Core and power switch models
  // --------------------------------------------------
  always @(negedge FCLK)
  begin
    sleepholdack_n <= sleepholdreq_n;
    wicenack       <= wicenreq;
    // Switch acks three cycles after the request
    pd_pipe        <= {pd_pipe[0], syspwrdown};
    syspwrdownack  <= pd_pipe[1];
  end

  // Order monitor checks one control step per cycle
  // and isolate before retain before power-down in both directions
  assign ctl_now  = {sysisolate_n, sysretain_n, syspwrdown};
  assign ctl_diff = ctl_now ^ ctl_prev;

  always @(negedge FCLK)
  begin
    if (PORESETn)
    begin
      if ((ctl_diff[0] & ctl_diff[1]) | (ctl_diff[0] & ctl_diff[2]) |
          (ctl_diff[1] & ctl_diff[2]) | (syspwrdown & sysretain_n) |
          (sysisolate_n & ~sysretain_n))
      begin
        $display("Domain controls stepped out of order at %0t ns", $time);
        error_count++;
      end
    end
    ctl_prev <= ctl_now;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 16'hB400;
    return n;
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      val  = (val << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic compare_state(input string name, input pmu_pkg::power_state_t exp,
                               input pmu_pkg::power_state_t act);
    if (act !== exp)
    begin
      $display("ERROR at %0t ns: %s expected %s, got %s", $time, name, exp.name(), act.name());
      error_count++;
    end
  endtask

  // Settled once sclk_en matches and no output moved for SETTLE cycles
  task automatic wait_settle(input row_t r, output bit ok);
    logic [7:0] snap;
    logic [7:0] prev;
    int stable;
    int cycles;
    ok     = 1'b0;
    stable = 0;
    cycles = 0;
    prev   = 'x;
    while (!ok && cycles < TIMEOUT)
    begin
      @(negedge FCLK);
      snap = {sysisolate_n, sysretain_n, syspwrdown, sclk_en,
              hclk_en, wicenreq, pmu_hresetreq, sleepholdreq_n};
      stable = (snap === prev) ? stable + 1 : 0;
      prev   = snap;
      cycles++;
      if (sclk_en === r.sclk && stable >= SETTLE)
        ok = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  // Columns are en sd wk hr gh rst_chk then iso ret pd sclk hclk wic hrq hold_n
  initial
  begin
    table_q[0] = '{0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 1, 0, 0, 1};  // Power-up from reset
    table_q[1] = '{1, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0};  // WIC deep sleep powers down
    table_q[2] = '{1, 1, 1, 0, 0, 0, 1, 1, 0, 1, 1, 1, 0, 0};  // Wakeup restores power
    table_q[3] = '{1, 0, 0, 0, 0, 0, 1, 1, 0, 1, 1, 1, 0, 1};  // Sleep ends and hold drops
    table_q[4] = '{1, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0};  // Down again
    table_q[5] = '{1, 1, 0, 1, 0, 1, 1, 1, 0, 1, 1, 1, 0, 0};  // hresetreq wakes
    table_q[6] = '{1, 0, 0, 1, 0, 0, 1, 1, 0, 1, 1, 1, 0, 1};  // Sleepdeep dropped first
    table_q[7] = '{1, 0, 0, 0, 1, 0, 1, 1, 0, 1, 0, 1, 0, 1};  // Bus clock gated
    table_q[8] = '{0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 1, 0, 0, 1};  // PMU disabled
    table_q[9] = '{0, 1, 0, 0, 0, 0, 1, 1, 0, 1, 1, 0, 0, 1};  // Sleepdeep ignored
  end

  initial
  begin
    int errs_before;
    int gap;
    bit ok;
    pmu_pkg::power_state_t exp_state;
    pmu_pkg::power_state_t act_state;
    PORESETn = 1'b0;
    pmu_enable = 1'b0;
    hresetreq = 1'b0;
    wicenack = 1'b0;
    wakeup = 1'b0;
    sleepdeep = 1'b0;
    sleepholdack_n = 1'b1;
    gatehclk = 1'b0;
    syspwrdownack = 1'b0;
    pd_pipe = 2'b00;
    ctl_prev = 3'b000;
    lfsr = 16'd56;
    error_count = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (5) @(posedge FCLK);
    @(negedge FCLK);
    PORESETn = 1'b1;
    for (int i = 0; i < ROWS; i++)
    begin
      errs_before = error_count;
      @(negedge FCLK);
      {pmu_enable, sleepdeep, wakeup, hresetreq, gatehclk} =
        {table_q[i].en, table_q[i].sd, table_q[i].wk, table_q[i].hr, table_q[i].gh};
      // Reset request passes straight through while the domain is off
      if (table_q[i].rst_chk)
      begin
        @(negedge FCLK);
        compare_bit("pmu_hresetreq", 1'b1, pmu_hresetreq);
      end
      exp_state = table_q[i].sclk ? pmu_pkg::powered_up : pmu_pkg::powered_down;
      wait_settle(table_q[i], ok);
      if (!ok)
      begin
        $display("Test %0d: timed out waiting for the domain to settle", i);
        error_count++;
      end
      act_state = DUT.u_sys_domain.sys_state;
      compare_state("sys_state", exp_state, act_state);
      compare_bit("sysisolate_n", table_q[i].iso, sysisolate_n);
      compare_bit("sysretain_n", table_q[i].ret, sysretain_n);
      compare_bit("syspwrdown", table_q[i].pd, syspwrdown);
      compare_bit("sclk_en", table_q[i].sclk, sclk_en);
      compare_bit("hclk_en", table_q[i].hclk, hclk_en);
      compare_bit("wicenreq", table_q[i].wic, wicenreq);
      compare_bit("pmu_hresetreq", table_q[i].hrq, pmu_hresetreq);
      compare_bit("sleepholdreq_n", table_q[i].hold_n, sleepholdreq_n);
      if (error_count == errs_before)
        pass_count++;
      else
        fail_count++;
      $display("Test %0d: %s, state %s", i, (error_count == errs_before) ? "PASS" : "FAIL",
               act_state.name());
      // Random idle gap of 0 to 7 cycles
      take_bits(3, gap);
      repeat (gap) @(negedge FCLK);
    end
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             ROWS, pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+logic
logic/pmu_pkg.sv
logic/pmu_input_sync.sv
logic/pmu_sleep_hold.sv
logic/pmu_sys_domain.sv
logic/pmu_top.sv
testbench/pmu_tb.sv

// ==== Bender.yml ====
package:
  name: pmu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/pmu_pkg.sv
      - logic/pmu_input_sync.sv
      - logic/pmu_sleep_hold.sv
      - logic/pmu_sys_domain.sv
      - logic/pmu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/pmu_tb.sv
